// File: sim.f
src/rv32i_pkg.sv
src/regfile.sv
src/alu.sv
src/forward_unit.sv
src/decode.sv
src/execute.sv
src/result.sv
src/rv32i_ex_top.sv
sim/tb_rv32i_ex.sv

// File: run_sim.sh
#!/bin/sh
# build and run the rv32i execute slice testbench with verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rv32i_ex -f sim.f -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Done: no errors$" sim.log; then
    exit 0
fi
exit 1

// File: sim/tb_rv32i_ex.sv
`timescale 1ns/1ps

module tb_rv32i_ex import rv32i_pkg::*; ();

    localparam int        PROG_WORDS = 64;
    localparam rv32i_word BASE       = 32'h0000_1000;

    logic      clk;
    logic      arst_n;
    logic      instr_valid;
    instr_u    instr;
    rv32i_word pc;
    wb_t       wb;
    redirect_t redirect;

    rv32i_word   prog [PROG_WORDS];
    int          prog_len;
    rv32i_word   ref_regs [32];
    wb_t         exp_wb [$];
    redirect_t   exp_redir [$];
    logic [15:0] lfsr;
    int          errors;
    int          tests_run;
    int          failed_tests;
    int          cycle_count = 0;
    int          cycle_limit = 10;    // reset plus slack, grows per test

    rv32i_ex_top #(
        .NUM_REGS (32)
    ) i_rv32i_ex_top (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .wb          (wb),
        .redirect    (redirect)
    );

    always #2 clk = ~clk;

    // galois lfsr, one step per bit
    function automatic rv32i_word rand_bits(input int n);
        rv32i_word v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic rv32i_word rtype(input logic [6:0] f7, input rv32i_reg rs2,
                                        input rv32i_reg rs1, input logic [2:0] f3,
                                        input rv32i_reg rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic rv32i_word itype(input logic [11:0] imm12, input rv32i_reg rs1,
                                        input logic [2:0] f3, input rv32i_reg rd,
                                        input logic [6:0] opc);
        return {imm12, rs1, f3, rd, opc};
    endfunction

    function automatic rv32i_word btype(input logic [12:0] off, input rv32i_reg rs2,
                                        input rv32i_reg rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic rv32i_word utype(input logic [19:0] imm20, input rv32i_reg rd,
                                        input logic [6:0] opc);
        return {imm20, rd, opc};
    endfunction

    function automatic rv32i_word jtype(input logic [20:0] off, input rv32i_reg rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // isa semantics indexed by funct3
    function automatic rv32i_word alu_model(input logic [2:0] f3, input logic alt,
                                            input rv32i_word a, input rv32i_word b);
        logic [4:0] s;
        s = b[4:0];
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << s;
            3'd2:    return {31'b0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? (a[31] ? ~(~a >> s) : a >> s) : a >> s;
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_model(input logic [2:0] f3, input rv32i_word a,
                                          input rv32i_word b);
        logic lt_s;
        lt_s = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);    // flip sign bit
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return lt_s;
            3'd5:    return !lt_s;
            3'd6:    return a < b;
            3'd7:    return !(a < b);
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic in_program(input rv32i_word addr);
        return addr >= BASE && ((addr - BASE) >> 2) < 32'(prog_len);
    endfunction

    task automatic emit(input rv32i_word w);
        prog[6'(prog_len)] = w;
        prog_len++;
    endtask

    task automatic load_const(input rv32i_reg rd, input rv32i_word v);
        rv32i_word hi;
        hi = v + 32'h800;    // addi sign-extends the low part
        emit(utype(hi[31:12], rd, 7'b0110111));
        emit(itype(v[11:0], rd, 3'b000, rd, 7'b0010011));
    endtask

    task automatic check_wb(input wb_t exp, input wb_t got);
        if (got !== exp) begin
            $display("[FAIL] wb expected rd=%h data=%h, got rd=%h data=%h",
                     exp.rd, exp.data, got.rd, got.data);
            errors++;
        end
    endtask

    task automatic check_redirect(input redirect_t exp, input redirect_t got);
        if (got !== exp) begin
            $display("[FAIL] redirect expected take=%h target=%h, got take=%h target=%h",
                     exp.take, exp.target, got.take, got.target);
            errors++;
        end
    endtask

    // architectural run in program order
    task automatic predict_program();
        rv32i_word rpc, w, a, b, val, target;
        rv32i_word immi, immb, immj;
        logic [2:0] f3;
        logic       writes, taken;
        int         steps;
        wb_t        e_wb;
        redirect_t  e_rd;
        exp_wb.delete();
        exp_redir.delete();
        rpc   = BASE;
        steps = 0;
        while (in_program(rpc) && steps < 4 * PROG_WORDS) begin
            w      = prog[6'((rpc - BASE) >> 2)];
            f3     = w[14:12];
            a      = ref_regs[w[19:15]];
            b      = ref_regs[w[24:20]];
            immi   = {{20{w[31]}}, w[31:20]};
            immb   = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            immj   = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            writes = 1'b1;
            taken  = 1'b0;
            val    = '0;
            target = '0;
            case (w[6:0])
                7'b0110011: val = alu_model(f3, w[30], a, b);
                7'b0010011: val = alu_model(f3, f3 == 3'b101 && w[30], a, immi);
                7'b0110111: val = {w[31:12], 12'b0};
                7'b0010111: val = rpc + {w[31:12], 12'b0};
                7'b1100011: begin
                    writes = 1'b0;
                    taken  = branch_model(f3, a, b);
                    target = rpc + immb;
                end
                7'b1101111: begin
                    val    = rpc + 32'd4;
                    taken  = 1'b1;
                    target = rpc + immj;
                end
                7'b1100111: begin
                    val    = rpc + 32'd4;
                    taken  = 1'b1;
                    target = (a + immi) & ~32'd1;
                end
                default: writes = 1'b0;
            endcase
            if (writes && w[11:7] != 5'd0) begin
                ref_regs[w[11:7]] = val;
                e_wb = '{1'b1, w[11:7], val};
                exp_wb.push_back(e_wb);
            end
            if (taken) begin
                e_rd = '{1'b1, target};
                exp_redir.push_back(e_rd);
                rpc = target;
            end else begin
                rpc = rpc + 32'd4;
            end
            steps++;
        end
    endtask

    // fetch model: follows redirects, squashed word is not re-fetched
    task automatic run_program(input string name);
        rv32i_word fpc;
        int        start_errors;
        start_errors = errors;
        cycle_limit += prog_len + 20;
        predict_program();
        fpc = BASE;
        while (in_program(fpc)) begin
            @(posedge clk);
            instr_valid <= 1'b1;
            instr       <= prog[6'((fpc - BASE) >> 2)];
            pc          <= fpc;
            @(negedge clk);
            if (redirect.take) fpc = redirect.target;
            else fpc = fpc + 32'd4;
        end
        @(posedge clk);
        instr_valid <= 1'b0;
        repeat (4) @(posedge clk);    // three edge latency plus one
        if (exp_wb.size() != 0) begin
            $display("%s: %0d expected writebacks never appeared", name, exp_wb.size());
            errors++;
        end
        if (exp_redir.size() != 0) begin
            $display("%s: %0d expected redirects never appeared", name, exp_redir.size());
            errors++;
        end
        tests_run++;
        if (errors == start_errors) begin
            $display("%-10s passed", name);
        end else begin
            failed_tests++;
            $display("%-10s failed with %0d errors", name, errors - start_errors);
        end
    endtask

    task automatic alu_ops_test();
        logic [3:0]  rr_ops [10];
        logic [3:0]  ri_ops [9];
        logic [11:0] imm12;
        rr_ops   = '{4'h0, 4'h8, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'hd, 4'h6, 4'h7};
        ri_ops   = '{4'h0, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'hd, 4'h6, 4'h7};
        prog_len = 0;
        load_const(5'd1, rand_bits(32));
        load_const(5'd2, rand_bits(32));
        for (int k = 0; k < 10; k++) begin
            emit(rtype({1'b0, rr_ops[k][3], 5'b0}, 5'd2, 5'd1, rr_ops[k][2:0], 5'(k + 3)));
        end
        for (int k = 0; k < 9; k++) begin
            if (ri_ops[k][1:0] == 2'b01) begin
                imm12 = {1'b0, ri_ops[k][3], 5'b0, 5'(rand_bits(5))};    // shamt form
            end else begin
                imm12 = 12'(rand_bits(12));
            end
            emit(itype(imm12, 5'd1, ri_ops[k][2:0], 5'(k + 13), 7'b0010011));
        end
        run_program("alu_ops");
    endtask

    task automatic upper_imm_test();
        prog_len = 0;
        emit(utype(20'(rand_bits(20)), 5'd3, 7'b0110111));
        emit(utype(20'(rand_bits(20)), 5'd4, 7'b0010111));
        emit(utype(20'h80000, 5'd5, 7'b0110111));
        emit(utype(20'hfffff, 5'd6, 7'b0010111));    // wraps below pc
        emit(rtype(7'd0, 5'd4, 5'd3, 3'b000, 5'd7));
        run_program("upper_imm");
    endtask

    task automatic hazards_test();
        prog_len = 0;
        emit(itype(12'(rand_bits(12)), 5'd0, 3'b000, 5'd1, 7'b0010011));
        emit(itype(12'd3, 5'd1, 3'b000, 5'd2, 7'b0010011));     // x1 at distance 1
        emit(rtype(7'd0, 5'd2, 5'd1, 3'b100, 5'd3));            // x1 at 2, x2 at 1
        emit(rtype(7'h20, 5'd3, 5'd1, 3'b000, 5'd4));           // x1 at 3
        emit(rtype(7'd0, 5'd4, 5'd2, 3'b000, 5'd5));
        emit(itype(12'd9, 5'd5, 3'b000, 5'd0, 7'b0010011));     // write to x0
        emit(rtype(7'd0, 5'd5, 5'd0, 3'b000, 5'd6));
        emit(rtype(7'd0, 5'd0, 5'd0, 3'b110, 5'd7));
        emit(itype(12'd1, 5'd1, 3'b000, 5'd1, 7'b0010011));
        emit(itype(12'd1, 5'd1, 3'b000, 5'd1, 7'b0010011));
        emit(rtype(7'd0, 5'd1, 5'd1, 3'b000, 5'd8));            // newest x1 wins
        run_program("hazards");
    endtask

    task automatic branches_test();
        logic [2:0] f3s [6];
        rv32i_reg   t1 [6];
        rv32i_reg   t2 [6];
        rv32i_reg   n1 [6];
        rv32i_reg   n2 [6];
        rv32i_word  a;
        f3s      = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        t1       = '{5'd1, 5'd1, 5'd1, 5'd2, 5'd2, 5'd1};
        t2       = '{5'd1, 5'd2, 5'd2, 5'd1, 5'd1, 5'd2};
        n1       = '{5'd1, 5'd1, 5'd2, 5'd1, 5'd1, 5'd2};
        n2       = '{5'd2, 5'd1, 5'd1, 5'd2, 5'd2, 5'd1};
        prog_len = 0;
        a = rand_bits(32);
        load_const(5'd1, a | 32'h8000_0000);    // negative, large unsigned
        a = rand_bits(32);
        load_const(5'd2, a & 32'h7fff_ffff);
        for (int k = 0; k < 6; k++) begin
            emit(btype(13'd8, t2[k], t1[k], f3s[k]));
            emit(itype(12'(k), 5'd0, 3'b000, 5'd9, 7'b0010011));    // squashed
            emit(btype(13'd8, n2[k], n1[k], f3s[k]));
            emit(itype(12'(k + 8), 5'd0, 3'b000, 5'd10, 7'b0010011));
            emit(itype(12'(k + 16), 5'd0, 3'b000, 5'd11, 7'b0010011));
        end
        run_program("branches");
    endtask

    task automatic jumps_test();
        prog_len = 0;
        emit(jtype(21'd12, 5'd1));
        emit(itype(12'd1, 5'd0, 3'b000, 5'd5, 7'b0010011));
        emit(itype(12'd2, 5'd0, 3'b000, 5'd6, 7'b0010011));
        emit(utype(20'd0, 5'd2, 7'b0010111));
        emit(itype(12'd13, 5'd2, 3'b000, 5'd3, 7'b1100111));    // odd offset, bit 0 dropped
        emit(itype(12'd3, 5'd0, 3'b000, 5'd7, 7'b0010011));
        emit(rtype(7'd0, 5'd3, 5'd1, 3'b000, 5'd8));
        emit(jtype(21'd8, 5'd0));
        emit(itype(12'd4, 5'd0, 3'b000, 5'd9, 7'b0010011));
        emit(itype(12'd5, 5'd0, 3'b000, 5'd10, 7'b0010011));
        run_program("jumps");
    endtask

    // outputs sampled mid-cycle
    always @(negedge clk) begin
        wb_t       e_wb;
        redirect_t e_rd;
        if (arst_n) begin
            if (wb.valid) begin
                if (exp_wb.size() == 0) begin
                    $display("writeback to x%0d arrived when none was expected", wb.rd);
                    errors++;
                end else begin
                    e_wb = exp_wb.pop_front();
                    check_wb(e_wb, wb);
                end
            end
            if (redirect.take) begin
                if (exp_redir.size() == 0) begin
                    $display("redirect to %h arrived when none was expected", redirect.target);
                    errors++;
                end else begin
                    e_rd = exp_redir.pop_front();
                    check_redirect(e_rd, redirect);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout: run went past %0d cycles", cycle_limit);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        clk          = 1'b0;
        arst_n       = 1'b0;
        instr_valid  = 1'b0;
        instr        = '0;
        pc           = '0;
        lfsr         = 16'd4126;
        errors       = 0;
        tests_run    = 0;
        failed_tests = 0;
        prog_len     = 0;
        ref_regs     = '{default: '0};
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;

        alu_ops_test();
        upper_imm_test();
        hazards_test();
        branches_test();
        jumps_test();

        $display("%0d tests, %0d failed, %0d errors", tests_run, failed_tests, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: src/rv32i_ex_top.sv
`timescale 1ns/1ps

module rv32i_ex_top import rv32i_pkg::*; #(
    parameter int NUM_REGS = 32
) (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      instr_valid,
    input  instr_u    instr,
    input  rv32i_word pc,
    output wb_t       wb,
    output redirect_t redirect
);

    rv32i_reg  rs1, rs2;
    rv32i_word rs1_data, rs2_data;
    id_ex_t    id_ex;
    ex_mem_t   ex_out, ex_mem;
    rv32i_word ex_mem_rd_data;

    regfile #(
        .NUM_REGS (NUM_REGS)
    ) i_regfile (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1      (rs1),
        .rs2      (rs2),
        .wb       (wb),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    decode i_decode (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .redirect    (redirect),
        .rs1         (rs1),
        .rs2         (rs2),
        .id_ex       (id_ex)
    );

    execute i_execute (
        .id_ex               (id_ex),
        .ex_mem_rd           (ex_mem.rd),
        .ex_mem_load_regfile (ex_mem.load_regfile),
        .ex_mem_rd_data      (ex_mem_rd_data),
        .wb                  (wb),
        .ex_out              (ex_out),
        .redirect            (redirect)
    );

    result i_result (
        .clk            (clk),
        .arst_n         (arst_n),
        .ex_in          (ex_out),
        .ex_mem         (ex_mem),
        .ex_mem_rd_data (ex_mem_rd_data),
        .wb             (wb)
    );

endmodule

// File: src/result.sv
`timescale 1ns/1ps

module result import rv32i_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  ex_mem_t   ex_in,
    output ex_mem_t   ex_mem,
    output rv32i_word ex_mem_rd_data,
    output wb_t       wb
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_mem.valid        <= 1'b0;
            ex_mem.load_regfile <= 1'b0;
        end else begin
            ex_mem <= ex_in;
        end
    end

    // value selected here feeds both forwarding and MEM/WB
    always_comb begin
        unique case (ex_mem.wb_sel)
            u_imm:    ex_mem_rd_data = ex_mem.u_imm;
            pc_plus4: ex_mem_rd_data = ex_mem.pc_plus4;
            default:  ex_mem_rd_data = ex_mem.alu_out;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= ex_mem.valid & ex_mem.load_regfile;   // branches drop out here
            wb.rd    <= ex_mem.rd;
            wb.data  <= ex_mem_rd_data;
        end
    end

    a_wb_not_x0: assert property (@(posedge clk) disable iff (!arst_n)
        wb.valid |-> wb.rd != '0)
        else $error("writeback to x0 reached MEM/WB");

endmodule

// File: src/execute.sv
`timescale 1ns/1ps

module execute import rv32i_pkg::*; (
    input  id_ex_t    id_ex,
    input  rv32i_reg  ex_mem_rd,
    input  logic      ex_mem_load_regfile,
    input  rv32i_word ex_mem_rd_data,
    input  wb_t       wb,
    output ex_mem_t   ex_out,
    output redirect_t redirect
);

    data_forward_t forward_a, forward_b;
    rv32i_word     fwd_rs1, fwd_rs2;
    rv32i_word     alu_a, alu_b, alu_result;
    logic          br_en;
    logic          is_jal, is_jalr;

    assign is_jal  = (id_ex.ctrl_wd.opcode == op_jal);
    assign is_jalr = (id_ex.ctrl_wd.opcode == op_jalr);

    forward_unit i_forward_unit (
        .ex_mem_rd           (ex_mem_rd),
        .mem_wb_rd           (wb.rd),
        .ex_mem_load_regfile (ex_mem_load_regfile),
        .mem_wb_load_regfile (wb.valid),    // wb only valid for real writes
        .id_ex_rs1           (id_ex.ctrl_wd.rs1),
        .id_ex_rs2           (id_ex.ctrl_wd.rs2),
        .forward_a           (forward_a),
        .forward_b           (forward_b)
    );

    always_comb begin
        unique case (forward_a)
            ex_mem_fd: fwd_rs1 = ex_mem_rd_data;
            mem_wb_fd: fwd_rs1 = wb.data;
            default:   fwd_rs1 = id_ex.rs1_out;
        endcase

        unique case (forward_b)
            ex_mem_fd: fwd_rs2 = ex_mem_rd_data;
            mem_wb_fd: fwd_rs2 = wb.data;
            default:   fwd_rs2 = id_ex.rs2_out;
        endcase
    end

    assign alu_a = (id_ex.ctrl_wd.alumux1_sel == pc_out) ? id_ex.ctrl_wd.pc : fwd_rs1;
    assign alu_b = (id_ex.ctrl_wd.alumux2_sel == rs2_out) ? fwd_rs2 : id_ex.imm;

    alu i_alu (
        .alu_op (id_ex.ctrl_wd.alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .f      (alu_result)
    );

    // branch compare on forwarded operands
    always_comb begin
        unique case (id_ex.ctrl_wd.cmp_op)
            beq:     br_en = (fwd_rs1 == fwd_rs2);
            bne:     br_en = (fwd_rs1 != fwd_rs2);
            blt:     br_en = ($signed(fwd_rs1) < $signed(fwd_rs2));
            bge:     br_en = ($signed(fwd_rs1) >= $signed(fwd_rs2));
            bltu:    br_en = (fwd_rs1 < fwd_rs2);
            bgeu:    br_en = (fwd_rs1 >= fwd_rs2);
            default: br_en = 1'b0;
        endcase
    end

    assign redirect.take   = id_ex.valid & (is_jal | is_jalr | (id_ex.ctrl_wd.is_branch & br_en));
    assign redirect.target = is_jalr ? {alu_result[31:1], 1'b0} : alu_result;

    always_comb begin
        ex_out.valid        = id_ex.valid;
        ex_out.rd           = id_ex.rd;
        ex_out.load_regfile = id_ex.valid & id_ex.ctrl_wd.load_regfile;
        ex_out.wb_sel       = id_ex.ctrl_wd.wb_sel;
        ex_out.alu_out      = alu_result;
        ex_out.u_imm        = id_ex.imm;      // lui value
        ex_out.pc_plus4     = id_ex.ctrl_wd.pc + 32'd4;
    end

endmodule

// File: src/decode.sv
`timescale 1ns/1ps

module decode import rv32i_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      instr_valid,
    input  instr_u    instr,
    input  rv32i_word pc,
    input  rv32i_word rs1_data,
    input  rv32i_word rs2_data,
    input  redirect_t redirect,
    output rv32i_reg  rs1,
    output rv32i_reg  rs2,
    output id_ex_t    id_ex
);

    ctrl_word_t ctrl;
    rv32i_word  imm_i, imm_u, imm_b, imm_j;
    rv32i_word  imm_pick;
    logic       opcode_ok;
    id_ex_t     id_ex_d;

    assign rs1 = instr.r.rs1;
    assign rs2 = instr.r.rs2;

    assign imm_i = {{20{instr.i.imm[11]}}, instr.i.imm};
    assign imm_u = {instr.u.imm, 12'b0};
    assign imm_b = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                    instr.b.imm10_5, instr.b.imm4_1, 1'b0};
    assign imm_j = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
                    instr.j.imm11, instr.j.imm10_1, 1'b0};

    always_comb begin
        ctrl              = '0;
        ctrl.opcode       = rv32i_opcode_t'(instr.r.opcode);
        ctrl.alu_op       = alu_add;
        ctrl.cmp_op       = cmp_op_t'(instr.b.funct3);
        ctrl.alumux1_sel  = rs1_out;
        ctrl.alumux2_sel  = imm;
        ctrl.wb_sel       = alu_out;
        ctrl.load_regfile = 1'b1;
        ctrl.rs1          = instr.r.rs1;
        ctrl.rs2          = instr.r.rs2;
        ctrl.pc           = pc;
        imm_pick          = imm_i;
        opcode_ok         = 1'b1;

        unique case (instr.r.opcode)
            op_reg: begin
                ctrl.alu_op      = alu_op_t'({instr.r.funct7[5], instr.r.funct3});
                ctrl.alumux2_sel = rs2_out;
            end
            op_imm: begin
                // funct7 bit only matters for srai
                if (instr.i.funct3 == 3'b101) begin
                    ctrl.alu_op = alu_op_t'({instr.r.funct7[5], instr.i.funct3});
                end else begin
                    ctrl.alu_op = alu_op_t'({1'b0, instr.i.funct3});
                end
            end
            op_lui: begin
                ctrl.wb_sel = u_imm;
                imm_pick    = imm_u;
            end
            op_auipc: begin
                ctrl.alumux1_sel = pc_out;
                imm_pick         = imm_u;
            end
            op_br: begin
                ctrl.alumux1_sel  = pc_out;    // target = pc + b imm
                ctrl.is_branch    = 1'b1;
                ctrl.load_regfile = 1'b0;
                imm_pick          = imm_b;
            end
            op_jal: begin
                ctrl.alumux1_sel = pc_out;
                ctrl.wb_sel      = pc_plus4;
                imm_pick         = imm_j;
            end
            op_jalr: ctrl.wb_sel = pc_plus4;
            default: begin
                ctrl.load_regfile = 1'b0;
                opcode_ok         = 1'b0;
            end
        endcase

        if (instr.r.rd == '0) ctrl.load_regfile = 1'b0;   // x0 never written
    end

    always_comb begin
        id_ex_d.valid   = instr_valid & ~redirect.take;   // wrong path becomes a bubble
        id_ex_d.ctrl_wd = ctrl;
        id_ex_d.rd      = instr.r.rd;
        id_ex_d.rs1_out = rs1_data;
        id_ex_d.rs2_out = rs2_data;
        id_ex_d.imm     = imm_pick;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_ex.valid <= 1'b0;
        end else begin
            id_ex <= id_ex_d;
        end
    end

    a_opcode_supported: assert property (@(posedge clk) disable iff (!arst_n)
        instr_valid && !redirect.take |-> opcode_ok)
        else $error("unsupported opcode %h", instr.r.opcode);

endmodule

// File: src/forward_unit.sv
`timescale 1ns/1ps

module forward_unit import rv32i_pkg::*; (
    input  rv32i_reg      ex_mem_rd,
    input  rv32i_reg      mem_wb_rd,
    input  logic          ex_mem_load_regfile,
    input  logic          mem_wb_load_regfile,
    input  rv32i_reg      id_ex_rs1,
    input  rv32i_reg      id_ex_rs2,
    output data_forward_t forward_a,
    output data_forward_t forward_b
);

    // newest producer wins, so EX/MEM is checked first
    always_comb begin
        forward_a = id_ex_fd;
        if (ex_mem_load_regfile && ex_mem_rd != '0 && ex_mem_rd == id_ex_rs1) begin
            forward_a = ex_mem_fd;
        end else if (mem_wb_load_regfile && mem_wb_rd != '0 && mem_wb_rd == id_ex_rs1) begin
            forward_a = mem_wb_fd;
        end

        forward_b = id_ex_fd;
        if (ex_mem_load_regfile && ex_mem_rd != '0 && ex_mem_rd == id_ex_rs2) begin
            forward_b = ex_mem_fd;
        end else if (mem_wb_load_regfile && mem_wb_rd != '0 && mem_wb_rd == id_ex_rs2) begin
            forward_b = mem_wb_fd;
        end
    end

endmodule

// File: src/alu.sv
`timescale 1ns/1ps

module alu import rv32i_pkg::*; (
    input  alu_op_t   alu_op,
    input  rv32i_word a,
    input  rv32i_word b,
    output rv32i_word f
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        unique case (alu_op)
            alu_add:  f = a + b;
            alu_sub:  f = a - b;
            alu_sll:  f = a << shamt;
            alu_slt:  f = {31'b0, $signed(a) < $signed(b)};
            alu_sltu: f = {31'b0, a < b};
            alu_xor:  f = a ^ b;
            alu_srl:  f = a >> shamt;
            alu_sra:  f = rv32i_word'($signed(a) >>> shamt);
            alu_or:   f = a | b;
            alu_and:  f = a & b;
            default:  f = '0;
        endcase
    end

endmodule

// File: src/regfile.sv
`timescale 1ns/1ps

module regfile import rv32i_pkg::*; #(
    parameter int NUM_REGS = 32
) (
    input  logic      clk,
    input  logic      arst_n,
    input  rv32i_reg  rs1,
    input  rv32i_reg  rs2,
    input  wb_t       wb,
    output rv32i_word rs1_data,
    output rv32i_word rs2_data
);

    rv32i_word regs [NUM_REGS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int k = 0; k < NUM_REGS; k++) begin
                regs[k] <= '0;
            end
        end else if (wb.valid && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // write-through covers the distance-3 hazard
    assign rs1_data = (wb.valid && wb.rd != '0 && wb.rd == rs1) ? wb.data : regs[rs1];
    assign rs2_data = (wb.valid && wb.rd != '0 && wb.rd == rs2) ? wb.data : regs[rs2];

    // x0 reads back zero on either port
    a_x0_reads_zero: assert property (@(posedge clk) disable iff (!arst_n)
        (rs1 != '0 || rs1_data == '0) && (rs2 != '0 || rs2_data == '0))
        else $error("x0 read returned nonzero data");

endmodule

// File: src/rv32i_pkg.sv
package rv32i_pkg;

    typedef logic [31:0] rv32i_word;
    typedef logic [4:0]  rv32i_reg;

    typedef enum logic [6:0] {
        op_reg   = 7'b0110011,
        op_imm   = 7'b0010011,
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_br    = 7'b1100011,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111
    } rv32i_opcode_t;

    // encoded as {funct7[5], funct3}
    typedef enum logic [3:0] {
        alu_add  = 4'b0000,
        alu_sll  = 4'b0001,
        alu_slt  = 4'b0010,
        alu_sltu = 4'b0011,
        alu_xor  = 4'b0100,
        alu_srl  = 4'b0101,
        alu_or   = 4'b0110,
        alu_and  = 4'b0111,
        alu_sub  = 4'b1000,
        alu_sra  = 4'b1101
    } alu_op_t;

    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } cmp_op_t;

    typedef enum logic [1:0] {
        id_ex_fd  = 2'b00,
        ex_mem_fd = 2'b01,
        mem_wb_fd = 2'b10
    } data_forward_t;

    typedef enum logic {rs1_out, pc_out} alumux1_sel_t;
    typedef enum logic {imm, rs2_out} alumux2_sel_t;
    typedef enum logic [1:0] {alu_out, u_imm, pc_plus4} wb_sel_t;

    // instruction formats, fields msb first
    typedef struct packed {
        logic [6:0] funct7;
        rv32i_reg   rs2;
        rv32i_reg   rs1;
        logic [2:0] funct3;
        rv32i_reg   rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        rv32i_reg    rs1;
        logic [2:0]  funct3;
        rv32i_reg    rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        rv32i_reg   rs2;
        rv32i_reg   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_type_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        rv32i_reg   rs2;
        rv32i_reg   rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0] imm;
        rv32i_reg    rd;
        logic [6:0]  opcode;
    } u_type_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        rv32i_reg   rd;
        logic [6:0] opcode;
    } j_type_t;

    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
        b_type_t b;
        u_type_t u;
        j_type_t j;
    } instr_u;

    typedef struct packed {
        rv32i_opcode_t opcode;
        alu_op_t       alu_op;
        cmp_op_t       cmp_op;
        alumux1_sel_t  alumux1_sel;
        alumux2_sel_t  alumux2_sel;
        wb_sel_t       wb_sel;
        logic          is_branch;
        logic          load_regfile;
        rv32i_reg      rs1;
        rv32i_reg      rs2;
        rv32i_word     pc;
    } ctrl_word_t;

    typedef struct packed {
        logic       valid;
        ctrl_word_t ctrl_wd;
        rv32i_reg   rd;
        rv32i_word  rs1_out;
        rv32i_word  rs2_out;
        rv32i_word  imm;        // already picked for the format
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        rv32i_reg  rd;
        logic      load_regfile;
        wb_sel_t   wb_sel;
        rv32i_word alu_out;
        rv32i_word u_imm;
        rv32i_word pc_plus4;
    } ex_mem_t;

    typedef struct packed {
        logic      valid;
        rv32i_reg  rd;
        rv32i_word data;
    } wb_t;

    typedef struct packed {
        logic      take;
        rv32i_word target;
    } redirect_t;

endpackage
